/* rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeE;

  // alu operations, branch compares go through funct3 instead
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
    aluSll, aluSrl, aluSra, aluPassB
  } aluOpE;

  // data memory access width, matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    accByte = 2'd0,
    accHalf = 2'd1,
    accWord = 2'd2
  } accWidthE;

  // one decoded instruction
  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    aluOpE       aluOp;
    logic [2:0]  funct3;
    accWidthE    width;
    logic        regWen;
    logic        memWen;
    logic        isLoad;
    logic        isBranch;
    logic        isJal;
    logic        isJalr;
    logic        useImm;
    logic        usePc;
    logic        isUnsigned;
    logic        isEbreak;
    logic        isIllegal;
  } decodedT;

endpackage

`default_nettype wire

/* pipePkg.sv */
`default_nettype none

package pipePkg;

  import rvIsaPkg::*;

  // fetch to decode stage register
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic        valid;
  } ifIdT;

  // decode to execute stage register, operands already forwarded
  typedef struct packed {
    logic [31:0] pc;
    decodedT     dec;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic        valid;
  } idExT;

  // one retired instruction
  // rd is zero when nothing is written
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } retireT;

  // addi x0, x0, 0
  localparam logic [31:0] nopInst = 32'h0000_0013;

endpackage

`default_nettype wire

/* instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder import rvIsaPkg::*; (
  input  logic [31:0] inst,
  output decodedT     decoded
);

  opcodeE     opcode;
  logic [2:0] f3;
  logic [6:0] f7;

  assign opcode = opcodeE'(inst[6:0]);
  assign f3     = inst[14:12];
  assign f7     = inst[31:25];

  // shared funct3 mapping of register and immediate alu ops
  // alt is funct7 bit 5, sub only exists in the register form
  function automatic aluOpE aluFromF3(input logic [2:0] fn, input logic alt, input logic isReg);
    aluOpE op;
    case (fn)
      3'b000:  op = (isReg && alt) ? aluSub : aluAdd;
      3'b001:  op = aluSll;
      3'b010:  op = aluSlt;
      3'b011:  op = aluSltu;
      3'b100:  op = aluXor;
      3'b101:  op = alt ? aluSra : aluSrl;
      3'b110:  op = aluOr;
      default: op = aluAnd;
    endcase
    return op;
  endfunction

  always_comb begin
    // defaults describe a no-op that writes nothing
    decoded        = '0;
    decoded.rd     = inst[11:7];
    decoded.rs1    = inst[19:15];
    decoded.rs2    = inst[24:20];
    decoded.funct3 = f3;
    decoded.aluOp  = aluAdd;
    decoded.width  = accWord;
    case (opcode)
      opLui: begin
        decoded.imm    = {inst[31:12], 12'b0};
        decoded.aluOp  = aluPassB;
        decoded.regWen = 1'b1;
        decoded.useImm = 1'b1;
      end
      opAuipc, opJal: begin
        // both add an offset to pc, jal links pc+4 instead
        decoded.imm    = (opcode == opJal) ?
                         {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0} :
                         {inst[31:12], 12'b0};
        decoded.regWen = 1'b1;
        decoded.usePc  = 1'b1;
        decoded.useImm = 1'b1;
        decoded.isJal  = (opcode == opJal);
      end
      opJalr: begin
        decoded.imm       = {{20{inst[31]}}, inst[31:20]};
        decoded.regWen    = (f3 == 3'b000);
        decoded.useImm    = 1'b1;
        decoded.isJalr    = (f3 == 3'b000);
        decoded.isIllegal = (f3 != 3'b000);
      end
      opBranch: begin
        // alu compares rs1 with rs2, target built in pipeControl
        decoded.imm       = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        decoded.isBranch  = (f3[2:1] != 2'b01);
        decoded.isIllegal = (f3[2:1] == 2'b01);
      end
      opLoad: begin
        // lb lh lw lbu lhu only
        decoded.imm        = {{20{inst[31]}}, inst[31:20]};
        decoded.width      = (f3[1:0] == 2'b00) ? accByte :
                             (f3[1:0] == 2'b01) ? accHalf : accWord;
        decoded.isUnsigned = f3[2];
        decoded.useImm     = 1'b1;
        decoded.isIllegal  = (f3 == 3'b011) || (f3[2:1] == 2'b11);
        decoded.regWen     = !decoded.isIllegal;
        decoded.isLoad     = !decoded.isIllegal;
      end
      opStore: begin
        decoded.imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        decoded.width     = (f3[1:0] == 2'b00) ? accByte :
                            (f3[1:0] == 2'b01) ? accHalf : accWord;
        decoded.useImm    = 1'b1;
        decoded.isIllegal = f3[2] || (f3[1:0] == 2'b11);
        decoded.memWen    = !decoded.isIllegal;
      end
      opImm: begin
        decoded.imm       = {{20{inst[31]}}, inst[31:20]};
        decoded.aluOp     = aluFromF3(f3, f7[5], 1'b0);
        decoded.useImm    = 1'b1;
        // shift immediates need a clean funct7
        decoded.isIllegal = ((f3 == 3'b001) && (f7 != 7'b0000000)) ||
                            ((f3 == 3'b101) && (f7 != 7'b0000000) && (f7 != 7'b0100000));
        decoded.regWen    = !decoded.isIllegal;
      end
      opReg: begin
        decoded.aluOp     = aluFromF3(f3, f7[5], 1'b1);
        decoded.isIllegal = !((f7 == 7'b0000000) ||
                              ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
        decoded.regWen    = !decoded.isIllegal;
      end
      opSystem: begin
        // ebreak is the only system instruction kept
        decoded.isEbreak  = (inst == 32'h0010_0073);
        decoded.isIllegal = (inst != 32'h0010_0073);
      end
      default: decoded.isIllegal = 1'b1;
    endcase
    // rd stays zero whenever the instruction writes nothing
    if (!decoded.regWen) begin
      decoded.rd = 5'd0;
    end
  end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1Data,
  output logic [31:0] rs2Data,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  // write lands at the end of the execute cycle
  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // reads see the old value during a write
  // same-cycle hazards are forwarded in pipeControl
  assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* execAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module execAlu import rvIsaPkg::*; (
  input  logic [31:0] opA,
  input  logic [31:0] opB,
  input  aluOpE       aluOp,
  input  logic [2:0]  funct3,
  output logic [31:0] aluResult,
  output logic        branchTaken
);

  logic [4:0] shamt;
  logic       lessS;
  logic       lessU;
  logic       equal;

  assign shamt = opB[4:0];
  assign lessS = $signed(opA) < $signed(opB);
  assign lessU = opA < opB;
  assign equal = opA == opB;

  always_comb begin
    case (aluOp)
      aluAdd:   aluResult = opA + opB;
      aluSub:   aluResult = opA - opB;
      aluAnd:   aluResult = opA & opB;
      aluOr:    aluResult = opA | opB;
      aluXor:   aluResult = opA ^ opB;
      aluSlt:   aluResult = {31'd0, lessS};
      aluSltu:  aluResult = {31'd0, lessU};
      aluSll:   aluResult = opA << shamt;
      aluSrl:   aluResult = opA >> shamt;
      aluSra:   aluResult = $unsigned($signed(opA) >>> shamt);
      aluPassB: aluResult = opB;
      default:  aluResult = 32'd0;
    endcase
  end

  // branch condition straight from funct3
  // only meaningful when the instruction is a branch
  always_comb begin
    case (funct3)
      3'b000:  branchTaken = equal;
      3'b001:  branchTaken = !equal;
      3'b100:  branchTaken = lessS;
      3'b101:  branchTaken = !lessS;
      3'b110:  branchTaken = lessU;
      3'b111:  branchTaken = !lessU;
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem import rvIsaPkg::*; #(
  parameter int dmemWords   = 256,
  parameter bit ramInitZero = 1'b1
) (
  input  logic        clk,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic        wen,
  input  logic        ren,
  input  accWidthE    width,
  input  logic        isUnsigned,
  output logic [31:0] rdata
);

  // word index wraps on the array size, a power of two
  localparam int idxBits = $clog2(dmemWords);

  logic [31:0]        mem [dmemWords];
  logic [idxBits-1:0] idx;
  logic [3:0]         laneMask;
  logic [31:0]        laneData;
  logic [31:0]        word;
  logic [31:0]        shifted;

  assign idx = addr[idxBits+1:2];

  initial begin
    if (ramInitZero) begin
      for (int i = 0; i < dmemWords; i++) begin
        mem[i] = 32'd0;
      end
    end
  end

  // replicate store data across lanes, mask picks the live ones
  always_comb begin
    case (width)
      accByte: begin
        laneData = {4{wdata[7:0]}};
        laneMask = 4'b0001 << addr[1:0];
      end
      accHalf: begin
        laneData = {2{wdata[15:0]}};
        laneMask = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        laneData = wdata;
        laneMask = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      for (int i = 0; i < 4; i++) begin
        if (laneMask[i]) begin
          mem[idx][8*i +: 8] <= laneData[8*i +: 8];
        end
      end
    end
  end

  // move the addressed byte or half down to bit 0
  assign word    = mem[idx];
  assign shifted = word >> {addr[1:0], 3'b000};

  always_comb begin
    case (width)
      accByte: rdata = {{24{!isUnsigned && shifted[7]}}, shifted[7:0]};
      accHalf: rdata = {{16{!isUnsigned && shifted[15]}}, shifted[15:0]};
      default: rdata = word;
    endcase
    if (!ren) begin
      rdata = 32'd0;
    end
  end

  aNaturalAlign: assert property (@(posedge clk)
    (wen || ren) |-> ((width == accHalf) ? !addr[0] :
                      (width == accWord) ? (addr[1:0] == 2'b00) : 1'b1))
    else $error("misaligned data access at %h", addr);

endmodule

`default_nettype wire

/* pipeControl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeControl import rvIsaPkg::*, pipePkg::*; #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] inst,
  output logic [31:0] fetchPc,
  output ifIdT        ifId,
  input  decodedT     decoded,
  input  logic [31:0] rs1Data,
  input  logic [31:0] rs2Data,
  output logic [31:0] opA,
  output logic [31:0] opB,
  output aluOpE       aluOp,
  output logic [2:0]  funct3,
  input  logic [31:0] aluResult,
  input  logic        branchTaken,
  output logic [31:0] memAddr,
  output logic [31:0] memWdata,
  output logic        memWen,
  output logic        memRen,
  output accWidthE    width,
  output logic        isUnsigned,
  input  logic [31:0] loadData,
  output logic        regWen,
  output logic [4:0]  regWaddr,
  output logic [31:0] regWdata,
  output retireT      retire,
  output logic        halted,
  output logic        illegal
);

  logic [31:0] pc;
  ifIdT        ifIdQ;
  idExT        idExQ;
  decodedT     exDec;
  logic        exCommit;
  logic        exEbreak;
  logic        exIllegal;
  logic        exWrites;
  logic        redirect;
  logic        squash;
  logic [31:0] target;
  logic [31:0] wbData;
  logic [31:0] rs1Fwd;
  logic [31:0] rs2Fwd;

  assign fetchPc = pc;
  assign ifId    = ifIdQ;
  assign exDec   = idExQ.dec;

  // execute stage status
  assign exEbreak  = idExQ.valid && exDec.isEbreak;
  assign exIllegal = idExQ.valid && exDec.isIllegal;
  assign exCommit  = idExQ.valid && !exDec.isIllegal;
  assign exWrites  = exCommit && exDec.regWen && (exDec.rd != 5'd0);

  // taken transfer, jump target has bit 0 cleared
  assign redirect = exCommit && (exDec.isJal || exDec.isJalr ||
                                 (exDec.isBranch && branchTaken));
  assign target   = exDec.isBranch ? (idExQ.pc + exDec.imm) : {aluResult[31:1], 1'b0};

  // bubbles on redirect, on the stopping instruction, and forever after
  assign squash = redirect || exEbreak || exIllegal || halted || illegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= resetPc;
    end else if (!(exEbreak || exIllegal || halted || illegal)) begin
      pc <= redirect ? target : pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ifIdQ <= '{pc: resetPc, inst: nopInst, valid: 1'b0};
    end else if (squash) begin
      ifIdQ <= '{pc: pc, inst: nopInst, valid: 1'b0};
    end else begin
      ifIdQ <= '{pc: pc, inst: inst, valid: 1'b1};
    end
  end

  // execute to decode forwarding, load data included so no stall
  assign rs1Fwd = (exWrites && (exDec.rd == decoded.rs1)) ? wbData : rs1Data;
  assign rs2Fwd = (exWrites && (exDec.rd == decoded.rs2)) ? wbData : rs2Data;

  always_ff @(posedge clk) begin
    if (rst) begin
      idExQ.valid <= 1'b0;
    end else begin
      idExQ <= '{pc: ifIdQ.pc, dec: decoded, rs1Val: rs1Fwd, rs2Val: rs2Fwd,
                 valid: ifIdQ.valid && !squash};
    end
  end

  // operand select
  assign opA    = exDec.usePc ? idExQ.pc : idExQ.rs1Val;
  assign opB    = exDec.useImm ? exDec.imm : idExQ.rs2Val;
  assign aluOp  = exDec.aluOp;
  assign funct3 = exDec.funct3;

  // memory strobes only for committing instructions
  assign memAddr    = aluResult;
  assign memWdata   = idExQ.rs2Val;
  assign memWen     = exCommit && exDec.memWen;
  assign memRen     = exCommit && exDec.isLoad;
  assign width      = exDec.width;
  assign isUnsigned = exDec.isUnsigned;

  // writeback: link for jumps, load data, else alu
  assign wbData = (exDec.isJal || exDec.isJalr) ? idExQ.pc + 32'd4 :
                  exDec.isLoad ? loadData : aluResult;

  assign regWen   = exCommit && exDec.regWen;
  assign regWaddr = exDec.rd;
  assign regWdata = wbData;

  assign retire = '{valid: exCommit, pc: idExQ.pc,
                    rd: exWrites ? exDec.rd : 5'd0,
                    data: exWrites ? wbData : 32'd0};

  // sticky stop flags, cleared only by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      halted  <= halted || exEbreak;
      illegal <= illegal || exIllegal;
    end
  end

  aNoRetireAfterHalt: assert property (@(posedge clk) disable iff (rst)
    $past(halted) |-> !retire.valid)
    else $error("retire after halt at pc %h", retire.pc);

  aAlignedTarget: assert property (@(posedge clk) disable iff (rst)
    redirect |-> (target[1:0] == 2'b00))
    else $error("unaligned redirect target %h", target);

endmodule

`default_nettype wire

/* rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore import rvIsaPkg::*, pipePkg::*; #(
  parameter logic [31:0] resetPc     = 32'h0,
  parameter int          dmemWords   = 256,
  parameter bit          ramInitZero = 1'b1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] inst,
  output logic [31:0] fetchPc,
  output retireT      retire,
  output logic        halted,
  output logic        illegal
);

  ifIdT        ifId;
  decodedT     decoded;
  logic [31:0] rs1Data;
  logic [31:0] rs2Data;
  logic [31:0] opA;
  logic [31:0] opB;
  aluOpE       aluOp;
  logic [2:0]  funct3;
  logic [31:0] aluResult;
  logic        branchTaken;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic        memWen;
  logic        memRen;
  accWidthE    width;
  logic        isUnsigned;
  logic [31:0] loadData;
  logic        regWen;
  logic [4:0]  regWaddr;
  logic [31:0] regWdata;

  pipeControl #(
    .resetPc (resetPc)
  ) u_pipeControl (
    .clk (clk), .rst (rst), .inst (inst), .fetchPc (fetchPc),
    .ifId (ifId), .decoded (decoded),
    .rs1Data (rs1Data), .rs2Data (rs2Data),
    .opA (opA), .opB (opB), .aluOp (aluOp), .funct3 (funct3),
    .aluResult (aluResult), .branchTaken (branchTaken),
    .memAddr (memAddr), .memWdata (memWdata), .memWen (memWen), .memRen (memRen),
    .width (width), .isUnsigned (isUnsigned), .loadData (loadData),
    .regWen (regWen), .regWaddr (regWaddr), .regWdata (regWdata),
    .retire (retire), .halted (halted), .illegal (illegal)
  );

  instDecoder u_instDecoder (
    .inst    (ifId.inst),
    .decoded (decoded)
  );

  // register reads addressed straight from the decoder
  regFile u_regFile (
    .clk (clk), .rs1 (decoded.rs1), .rs2 (decoded.rs2),
    .rs1Data (rs1Data), .rs2Data (rs2Data),
    .wen (regWen), .waddr (regWaddr), .wdata (regWdata)
  );

  execAlu u_execAlu (
    .opA (opA), .opB (opB), .aluOp (aluOp), .funct3 (funct3),
    .aluResult (aluResult), .branchTaken (branchTaken)
  );

  dataMem #(
    .dmemWords   (dmemWords),
    .ramInitZero (ramInitZero)
  ) u_dataMem (
    .clk (clk), .addr (memAddr), .wdata (memWdata), .wen (memWen), .ren (memRen),
    .width (width), .isUnsigned (isUnsigned), .rdata (loadData)
  );

endmodule

`default_nettype wire

/* tbRefModel.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] randBits(input int n);
  logic [31:0] r;
  logic fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    r = {r[30:0], fb};
  end
  return r;
endfunction

// instruction encoders
function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// alu result for both forms, alt selects sub or sra
function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'd0, $signed(a) < $signed(b)};
    3'd3: return {31'd0, a < b};
    3'd4: return a ^ b;
    3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branchCond(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

// byte memory, wraps at 1 KiB like the 256-word dut array
function automatic logic [31:0] loadRef(input logic [2:0] f3, input logic [31:0] addr);
  logic [31:0] w;
  for (int i = 0; i < 4; i++) begin
    w[8*i +: 8] = refMem[10'(addr + i)];
  end
  case (f3)
    3'd0: return {{24{w[7]}}, w[7:0]};
    3'd4: return {24'd0, w[7:0]};
    3'd1: return {{16{w[15]}}, w[15:0]};
    3'd5: return {16'd0, w[15:0]};
    default: return w;
  endcase
endfunction

function automatic void storeRef(input logic [2:0] f3, input logic [31:0] addr,
                                 input logic [31:0] val);
  for (int i = 0; i < (1 << f3[1:0]); i++) begin
    refMem[10'(addr + i)] = val[8*i +: 8];
  end
endfunction

// one instruction on the model, returns what the dut should retire
function automatic void refStep(output logic [31:0] pc, output logic [4:0] rd,
                                output logic [31:0] data);
  logic [31:0] in;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] immI;
  logic [31:0] res;
  logic [31:0] nextPc;
  logic [2:0]  f3;
  logic        wr;
  in     = rom[refPc[9:2]];
  f3     = in[14:12];
  a      = refRegs[in[19:15]];
  b      = refRegs[in[24:20]];
  immI   = {{20{in[31]}}, in[31:20]};
  pc     = refPc;
  nextPc = refPc + 32'd4;
  wr     = 1'b1;
  res    = '0;
  case (in[6:0])
    7'h37: res = {in[31:12], 12'd0};
    7'h17: res = refPc + {in[31:12], 12'd0};
    7'h6f: begin
      res    = refPc + 32'd4;
      nextPc = refPc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
    end
    7'h67: begin
      res    = refPc + 32'd4;
      nextPc = (a + immI) & ~32'd1;
    end
    7'h63: begin
      wr = 1'b0;
      if (branchCond(f3, a, b)) begin
        nextPc = refPc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
      end
    end
    7'h03: res = loadRef(f3, a + immI);
    7'h23: begin
      wr = 1'b0;
      storeRef(f3, a + {{20{in[31]}}, in[31:25], in[11:7]}, b);
    end
    7'h13: res = aluRef(f3, in[30] && (f3 == 3'd5), a, immI);
    7'h33: res = aluRef(f3, in[30], a, b);
    7'h73: begin
      wr      = 1'b0;
      refHalt = 1'b1;
    end
    default: begin
      wr         = 1'b0;
      refIllegal = 1'b1;
    end
  endcase
  if (!refIllegal) begin
    refPc = nextPc;
  end
  rd   = (wr && in[11:7] != 5'd0) ? in[11:7] : 5'd0;
  data = (rd != 5'd0) ? res : 32'd0;
  if (rd != 5'd0) begin
    refRegs[rd] = res;
  end
endfunction

`endif

/* tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb import rvIsaPkg::*, pipePkg::*;;

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic [31:0] fetchPc;
  retireT      retire;
  logic        halted;
  logic        illegal;

  // rom and reference state
  logic [31:0] rom [0:255];
  logic [7:0]  refMem [0:1023];
  logic [31:0] refRegs [0:31];
  logic [31:0] refPc;
  logic        refHalt;
  logic        refIllegal;
  logic [31:0] lfsrState = 32'h383a1731;
  int          wp;
  int          retCount;
  int          expCount;
  logic        expectIllegal;

  `include "tbRefModel.svh"

  rvCore #(
    .resetPc     (32'h0),
    .dmemWords   (256),
    .ramInitZero (1'b1)
  ) u_dut (
    .clk (clk), .rst (rst), .inst (inst), .fetchPc (fetchPc),
    .retire (retire), .halted (halted), .illegal (illegal)
  );

  // rom read straight from the fetch address
  assign inst = rom[fetchPc[9:2]];

  always #2 clk = ~clk;

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic put(input logic [31:0] word);
    rom[wp] = word;
    wp++;
  endtask

  task automatic skipPair();
    // addi x20, x20, 1, twice
    put(encI(12'd1, 5'd20, 3'd0, 5'd20, 7'h13));
    put(encI(12'd1, 5'd20, 3'd0, 5'd20, 7'h13));
  endtask

  task automatic clearRom();
    for (int i = 0; i < 256; i++) begin
      rom[i] = nopInst;
    end
    wp = 0;
  endtask

  task automatic buildMain();
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    int          conds [6];
    conds = '{0, 1, 4, 5, 6, 7};
    clearRom();
    // x1 = 12345678, x2 = base 0x40, x3 = ffffff80, x20 = 0
    put({20'h12345, 5'd1, 7'h37});
    put(encI(12'h678, 5'd1, 3'd0, 5'd1, 7'h13));
    put(encI(12'h040, 5'd0, 3'd0, 5'd2, 7'h13));
    put(encI(12'hf80, 5'd0, 3'd0, 5'd3, 7'h13));
    put(encI(12'd0, 5'd0, 3'd0, 5'd20, 7'h13));
    // stores of every width
    put(encS(12'd0, 5'd1, 5'd2, 3'd2));
    put(encS(12'd6, 5'd1, 5'd2, 3'd1));
    put(encS(12'd9, 5'd1, 5'd2, 3'd0));
    put(encS(12'd11, 5'd3, 5'd2, 3'd0));
    put(encS(12'd12, 5'd3, 5'd2, 3'd1));
    // load then immediate use
    put(encI(12'd0, 5'd2, 3'd2, 5'd4, 7'h03));
    put(encR(7'd0, 5'd4, 5'd4, 3'd0, 5'd5));
    put(encI(12'd3, 5'd2, 3'd0, 5'd6, 7'h03));
    put(encI(12'd3, 5'd2, 3'd4, 5'd7, 7'h03));
    put(encI(12'd6, 5'd2, 3'd1, 5'd8, 7'h03));
    put(encI(12'd2, 5'd2, 3'd5, 5'd9, 7'h03));
    put(encI(12'd11, 5'd2, 3'd0, 5'd10, 7'h03));
    put(encI(12'd11, 5'd2, 3'd4, 5'd11, 7'h03));
    put(encI(12'd12, 5'd2, 3'd1, 5'd12, 7'h03));
    put(encI(12'd12, 5'd2, 3'd5, 5'd13, 7'h03));
    // each condition both ways round, x1 positive and x3 negative
    put(encB(13'd12, 5'd1, 5'd1, 3'd0));
    skipPair();
    foreach (conds[i]) begin
      put(encB(13'd12, 5'd3, 5'd1, 3'(conds[i])));
      skipPair();
      put(encB(13'd12, 5'd1, 5'd3, 3'(conds[i])));
      skipPair();
    end
    put(encJ(21'd12, 5'd14));
    skipPair();
    // auipc then jalr over two fillers
    put({20'd0, 5'd15, 7'h17});
    put(encI(12'd16, 5'd15, 3'd0, 5'd16, 7'h67));
    skipPair();
    put(encR(7'd0, 5'd16, 5'd14, 3'd0, 5'd17));
    // random alu ops on a narrow register set for dense dependencies
    for (int n = 0; n < 60; n++) begin
      f3 = 3'(randBits(3));
      if (randBits(1) != 0) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && randBits(1) != 0) ? 7'h20 : 7'h00;
        put(encR(f7, 5'(randBits(4)), 5'(randBits(4)), f3, 5'(randBits(4) + 1)));
      end else begin
        imm = 12'(randBits(12));
        if (f3 == 3'd1) begin
          imm[11:5] = 7'h00;
        end
        if (f3 == 3'd5) begin
          imm[11:5] = (randBits(1) != 0) ? 7'h20 : 7'h00;
        end
        put(encI(imm, 5'(randBits(4)), f3, 5'(randBits(4) + 1), 7'h13));
      end
    end
    put(32'h0010_0073);
  endtask

  task automatic buildIllegal();
    clearRom();
    put(encI(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
    put(encI(12'd3, 5'd1, 3'd0, 5'd2, 7'h13));
    // opcode zero is outside the subset
    put(32'h0000_0000);
    put(encI(12'd1, 5'd0, 3'd0, 5'd3, 7'h13));
    put(32'h0010_0073);
  endtask

  task automatic refReset();
    refPc      = 32'h0;
    refHalt    = 1'b0;
    refIllegal = 1'b0;
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
      refMem[i] = '0;
    end
  endtask

  // expected retire count from a standalone model run
  task automatic countRef(output int cnt);
    logic [31:0] p;
    logic [4:0]  r;
    logic [31:0] d;
    refReset();
    cnt = 0;
    while (!refHalt && !refIllegal && cnt < 2000) begin
      refStep(p, r, d);
      if (!refIllegal) cnt++;
    end
    refReset();
  endtask

  task automatic resetDut();
    rst <= 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    retCount = 0;
  endtask

  task automatic waitStop(input bit wantIllegal);
    int n;
    n = 0;
    while (!(wantIllegal ? illegal : halted) && n < 5000) begin
      @(posedge clk);
      n++;
    end
    if (n >= 5000) begin
      if (wantIllegal) begin
        failNow("core never raised illegal");
      end else begin
        failNow("core never halted");
      end
    end
  endtask

  // compare every retire with the model
  always @(posedge clk) begin : compareRetire
    logic [31:0] expPc;
    logic [4:0]  expRd;
    logic [31:0] expData;
    if (!rst && retire.valid) begin
      assert (!refHalt && !refIllegal) else failNow("instruction retired after the core stopped");
      refStep(expPc, expRd, expData);
      assert (retire.pc == expPc)
        else failNow($sformatf("** Error: retire.pc = %h, expected %h", retire.pc, expPc));
      assert (retire.rd == expRd)
        else failNow($sformatf("** Error: retire.rd = %h, expected %h", retire.rd, expRd));
      assert (retire.data == expData)
        else failNow($sformatf("** Error: retire.data = %h, expected %h",
                               retire.data, expData));
      retCount++;
    end
    if (!rst) begin
      assert (!illegal || expectIllegal) else failNow("illegal raised on a legal program");
    end
  end

  initial begin : mainFlow
    logic [31:0] pcHold;
    logic [31:0] p;
    logic [4:0]  r;
    logic [31:0] d;
    clk           = 1'b0;
    rst           = 1'b1;
    expectIllegal = 1'b0;
    buildMain();
    countRef(expCount);
    resetDut();
    waitStop(1'b0);
    assert (refHalt) else failNow("core halted before the model reached ebreak");
    pcHold = fetchPc;
    repeat (10) @(posedge clk);
    assert (fetchPc == pcHold)
      else failNow($sformatf("** Error: fetchPc = %h, expected %h", fetchPc, pcHold));
    assert (retCount == expCount)
      else failNow($sformatf("** Error: retCount = %h, expected %h", retCount, expCount));
    // second run ends on an unsupported opcode
    buildIllegal();
    countRef(expCount);
    expectIllegal = 1'b1;
    resetDut();
    waitStop(1'b1);
    repeat (4) @(posedge clk);
    assert (!halted) else failNow("halted rose on the illegal run");
    refStep(p, r, d);
    assert (refIllegal) else failNow("illegal rose where the model expects a legal instruction");
    assert (retCount == expCount)
      else failNow($sformatf("** Error: retCount = %h, expected %h", retCount, expCount));
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
rvIsaPkg.sv
pipePkg.sv
instDecoder.sv
regFile.sv
execAlu.sv
dataMem.sv
pipeControl.sv
rvCore.sv
tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb
FILELIST  ?= tb.f

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
